// ==== cpu_pkg.sv ====
package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    // register writeback source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_t;

    // addi x0, x0, 0
    localparam xlen_t NOP_INSTR = 32'h0000_0013;

endpackage

// ==== fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage import cpu_pkg::*; #(
    parameter xlen_t RESET_PC = '0
) (
    input  logic  CLK,
    input  logic  RESET,
    input  logic  advance,
    input  logic  redirect,
    input  xlen_t target,
    output logic  fetch_valid,
    output xlen_t fetch_addr,
    input  xlen_t fetch_rdata,
    output xlen_t if_instr,
    output xlen_t if_pc
);

    xlen_t pc;

    // fetch is requested in every cycle outside reset
    assign fetch_valid = ~RESET;
    assign fetch_addr  = pc;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            pc       <= RESET_PC;
            if_instr <= NOP_INSTR;
        end
        else if (advance)
        begin
            pc <= redirect ? target : pc + 32'd4;
            // wrong-path fetch turns into a nop
            if_instr <= redirect ? NOP_INSTR : fetch_rdata;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (advance)
            if_pc <= pc;
    end

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage import cpu_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      advance,
    input  logic      flush,
    input  xlen_t     if_instr,
    input  xlen_t     if_pc,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input  xlen_t     rs1_data,
    input  xlen_t     rs2_data,
    output xlen_t     id_pc, id_rs1, id_rs2, id_imm,
    output reg_addr_t id_rs1_addr, id_rs2_addr, id_rd,
    output alu_op_t   id_alu_op,
    output logic      id_use_imm, id_is_branch, id_branch_ne, id_is_jal,
    output logic      id_mem_read, id_mem_write, id_reg_write,
    output wb_sel_t   id_wb_sel
);

    opcode_t opcode;
    logic    [2:0] funct3;
    xlen_t   imm_i, imm_s, imm_b, imm_j, imm;
    alu_op_t alu_op;
    logic    use_imm, is_branch, is_jal, mem_read, mem_write, reg_write;
    wb_sel_t wb_sel;

    assign opcode   = opcode_t'(if_instr[6:0]);
    assign funct3   = if_instr[14:12];
    assign rs1_addr = if_instr[19:15];
    assign rs2_addr = if_instr[24:20];

    assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
    assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
    assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                    if_instr[30:25], if_instr[11:8], 1'b0};
    assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12],
                    if_instr[20], if_instr[30:21], 1'b0};

    always_comb
    begin
        alu_op    = ALU_ADD;
        imm       = imm_i;
        use_imm   = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        wb_sel    = WB_ALU;
        case (opcode)
            OP:
            begin
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  alu_op = if_instr[30] ? ALU_SUB : ALU_ADD;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OP_IMM:
            begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            LOAD:
            begin
                use_imm   = 1'b1;
                mem_read  = 1'b1;
                reg_write = 1'b1;
                wb_sel    = WB_MEM;
            end
            STORE:
            begin
                imm       = imm_s;
                use_imm   = 1'b1;
                mem_write = 1'b1;
            end
            BRANCH:
            begin
                imm       = imm_b;
                is_branch = 1'b1;
            end
            JAL:
            begin
                imm       = imm_j;
                is_jal    = 1'b1;
                reg_write = 1'b1;
                wb_sel    = WB_PC4;
            end
            default:
            begin
            end
        endcase
    end

    // bubble on reset or flush
    always_ff @(posedge CLK)
    begin
        if (RESET || (advance && flush))
        begin
            id_is_branch <= 1'b0;
            id_is_jal    <= 1'b0;
            id_mem_read  <= 1'b0;
            id_mem_write <= 1'b0;
            id_reg_write <= 1'b0;
        end
        else if (advance)
        begin
            id_is_branch <= is_branch;
            id_is_jal    <= is_jal;
            id_mem_read  <= mem_read;
            id_mem_write <= mem_write;
            id_reg_write <= reg_write;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (advance)
        begin
            id_pc        <= if_pc;
            id_rs1       <= rs1_data;
            id_rs2       <= rs2_data;
            id_imm       <= imm;
            id_rs1_addr  <= rs1_addr;
            id_rs2_addr  <= rs2_addr;
            id_rd        <= if_instr[11:7];
            id_alu_op    <= alu_op;
            id_use_imm   <= use_imm;
            id_branch_ne <= funct3[0];
            id_wb_sel    <= wb_sel;
        end
    end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/10ps

module reg_file import cpu_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      advance,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output xlen_t     rs1_data,
    output xlen_t     rs2_data,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  xlen_t     wr_data
);

    // x0 has no storage
    xlen_t regs [1:31];

    function automatic xlen_t read_port(reg_addr_t addr);
        xlen_t val;
        if (addr == '0)
            val = '0;
        else if (wr_en && wr_addr == addr)
            val = wr_data;
        else
            val = regs[addr];
        return val;
    endfunction

    always_comb
    begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (advance && wr_en && wr_addr != '0)
            regs[wr_addr] <= wr_data;
    end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage import cpu_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      advance,
    input  xlen_t     id_pc, id_rs1, id_rs2, id_imm,
    input  reg_addr_t id_rs1_addr, id_rs2_addr, id_rd,
    input  alu_op_t   id_alu_op,
    input  logic      id_use_imm, id_is_branch, id_branch_ne, id_is_jal,
    input  logic      id_mem_read, id_mem_write, id_reg_write,
    input  wb_sel_t   id_wb_sel,
    input  reg_addr_t ex_fwd_rd,
    input  logic      ex_fwd_en,
    input  xlen_t     ex_fwd_data,
    input  reg_addr_t wb_fwd_rd,
    input  logic      wb_fwd_en,
    input  xlen_t     wb_fwd_data,
    output logic      redirect,
    output xlen_t     target,
    output xlen_t     ex_alu, ex_store_data, ex_pc4,
    output reg_addr_t ex_rd,
    output logic      ex_mem_read, ex_mem_write, ex_reg_write,
    output wb_sel_t   ex_wb_sel
);

    xlen_t op_a, op_b, alu_b, alu_out;
    logic  taken;

    // newest writer wins, memory stage before writeback
    function automatic xlen_t pick_operand(reg_addr_t addr, xlen_t reg_val);
        xlen_t val;
        val = reg_val;
        if (addr != '0 && wb_fwd_en && wb_fwd_rd == addr)
            val = wb_fwd_data;
        if (addr != '0 && ex_fwd_en && ex_fwd_rd == addr)
            val = ex_fwd_data;
        return val;
    endfunction

    always_comb
    begin
        op_a = pick_operand(id_rs1_addr, id_rs1);
        op_b = pick_operand(id_rs2_addr, id_rs2);
    end

    assign alu_b = id_use_imm ? id_imm : op_b;

    always_comb
    begin
        case (id_alu_op)
            ALU_SUB: alu_out = op_a - alu_b;
            ALU_AND: alu_out = op_a & alu_b;
            ALU_OR:  alu_out = op_a | alu_b;
            ALU_XOR: alu_out = op_a ^ alu_b;
            ALU_SLT: alu_out = {31'd0, $signed(op_a) < $signed(alu_b)};
            default: alu_out = op_a + alu_b;
        endcase
    end

    // beq on equal, bne on not equal
    assign taken    = id_is_branch & ((op_a == op_b) ^ id_branch_ne);
    assign redirect = taken | id_is_jal;
    assign target   = id_pc + id_imm;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_reg_write <= 1'b0;
        end
        else if (advance)
        begin
            ex_mem_read  <= id_mem_read;
            ex_mem_write <= id_mem_write;
            ex_reg_write <= id_reg_write;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (advance)
        begin
            ex_alu        <= alu_out;
            ex_store_data <= op_b;
            ex_pc4        <= id_pc + 32'd4;
            ex_rd         <= id_rd;
            ex_wb_sel     <= id_wb_sel;
        end
    end

endmodule

// ==== mem_wb_stage.sv ====
`timescale 1ns/10ps

module mem_wb_stage import cpu_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      advance,
    input  xlen_t     ex_alu, ex_store_data, ex_pc4,
    input  reg_addr_t ex_rd,
    input  logic      ex_mem_read, ex_mem_write, ex_reg_write,
    input  wb_sel_t   ex_wb_sel,
    output logic      data_valid,
    output logic      data_write,
    output xlen_t     data_addr,
    output xlen_t     data_wdata,
    input  xlen_t     data_rdata,
    output logic      wb_en,
    output reg_addr_t wb_rd,
    output xlen_t     wb_data,
    output xlen_t     ex_fwd_data
);

    assign data_valid = ex_mem_read | ex_mem_write;
    assign data_write = ex_mem_write;
    assign data_addr  = ex_alu;
    assign data_wdata = ex_store_data;

    // loads are not forwarded from here, the load data arrives too late
    assign ex_fwd_data = (ex_wb_sel == WB_PC4) ? ex_pc4 : ex_alu;

    always_ff @(posedge CLK)
    begin
        if (RESET)
            wb_en <= 1'b0;
        else if (advance)
            wb_en <= ex_reg_write;
    end

    always_ff @(posedge CLK)
    begin
        if (advance)
        begin
            wb_rd   <= ex_rd;
            wb_data <= (ex_wb_sel == WB_MEM) ? data_rdata : ex_fwd_data;
        end
    end

endmodule

// ==== mem_arbiter.sv ====
`timescale 1ns/10ps

module mem_arbiter import cpu_pkg::*; (
    input  logic  CLK,
    input  logic  RESET,
    input  logic  fetch_valid,
    input  xlen_t fetch_addr,
    output xlen_t fetch_rdata,
    input  logic  data_valid,
    input  logic  data_write,
    input  xlen_t data_addr,
    input  xlen_t data_wdata,
    output xlen_t data_rdata,
    output logic  advance,
    output logic  mem_valid,
    output logic  mem_write,
    output xlen_t mem_addr,
    output xlen_t mem_wdata,
    input  logic  mem_ready,
    input  xlen_t mem_rdata
);

    logic  data_done;
    logic  grant_data;
    logic  fetch_ready, data_ready;
    xlen_t rdata_q;

    // data goes first, fetch once the data transfer is done
    assign grant_data = data_valid & ~data_done;

    // the pipeline only moves while fetching, so fetch_valid covers data too
    assign mem_valid = fetch_valid;
    assign mem_write = grant_data & data_write;
    assign mem_addr  = grant_data ? data_addr : fetch_addr;
    assign mem_wdata = data_wdata;

    assign data_ready  = grant_data & mem_ready;
    assign fetch_ready = ~grant_data & mem_ready;

    // fetch transfer closes the cycle group
    assign advance = fetch_valid & fetch_ready;

    assign fetch_rdata = mem_rdata;
    assign data_rdata  = rdata_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
            data_done <= 1'b0;
        else if (advance)
            data_done <= 1'b0;
        else if (data_ready)
            data_done <= 1'b1;
    end

    // load word held until the group ends
    always_ff @(posedge CLK)
    begin
        if (data_ready)
            rdata_q <= mem_rdata;
    end

endmodule

// ==== rv_pipeline_top.sv ====
`timescale 1ns/10ps

module rv_pipeline_top import cpu_pkg::*; #(
    parameter xlen_t RESET_PC = '0
) (
    input  logic  CLK,
    input  logic  RESET,
    output logic  mem_valid,
    output logic  mem_write,
    output xlen_t mem_addr,
    output xlen_t mem_wdata,
    input  logic  mem_ready,
    input  xlen_t mem_rdata
);

    logic      advance;
    logic      redirect;
    xlen_t     target;

    // fetch side
    logic      fetch_valid;
    xlen_t     fetch_addr, fetch_rdata;
    xlen_t     if_instr, if_pc;

    // decode and register file
    reg_addr_t rs1_addr, rs2_addr;
    xlen_t     rs1_data, rs2_data;

    // ID/EX
    xlen_t     id_pc, id_rs1, id_rs2, id_imm;
    reg_addr_t id_rs1_addr, id_rs2_addr, id_rd;
    alu_op_t   id_alu_op;
    logic      id_use_imm, id_is_branch, id_branch_ne, id_is_jal;
    logic      id_mem_read, id_mem_write, id_reg_write;
    wb_sel_t   id_wb_sel;

    // EX/MEM
    xlen_t     ex_alu, ex_store_data, ex_pc4, ex_fwd_data;
    reg_addr_t ex_rd;
    logic      ex_mem_read, ex_mem_write, ex_reg_write;
    wb_sel_t   ex_wb_sel;

    // data request and MEM/WB
    logic      data_valid, data_write;
    xlen_t     data_addr, data_wdata, data_rdata;
    logic      wb_en;
    reg_addr_t wb_rd;
    xlen_t     wb_data;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch_stage (.*);

    // a redirect flushes the instruction sitting in IF/ID
    decode_stage u_decode_stage (.flush(redirect), .*);

    reg_file u_reg_file (.wr_en(wb_en), .wr_addr(wb_rd), .wr_data(wb_data), .*);

    execute_stage u_execute_stage (
        .ex_fwd_rd   (ex_rd),
        .ex_fwd_en   (ex_reg_write),
        .wb_fwd_rd   (wb_rd),
        .wb_fwd_en   (wb_en),
        .wb_fwd_data (wb_data),
        .*
    );

    mem_wb_stage u_mem_wb_stage (.*);

    mem_arbiter u_mem_arbiter (.*);

endmodule

// ==== tb_rv_ref.svh ====
// instruction-set model of the supported RV32I subset
// runs the program held in ref_mem and queues every store it makes
function automatic void ref_run();
    logic [31:0] regs [32];
    logic [31:0] pc, next_pc, instr, a, b, addr;
    logic [31:0] imm_i, imm_s, imm_b, imm_j;
    logic [4:0]  rd;
    logic [2:0]  f3;
    foreach (regs[i])
        regs[i] = '0;
    pc = RESET_PC;
    for (int steps = 0; steps < REF_STEP_LIMIT; steps++)
    begin
        instr   = ref_mem[pc[11:2]];
        rd      = instr[11:7];
        f3      = instr[14:12];
        a       = regs[instr[19:15]];
        b       = regs[instr[24:20]];
        imm_i   = {{20{instr[31]}}, instr[31:20]};
        imm_s   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_b   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_j   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        next_pc = pc + 32'd4;
        case (instr[6:0])
            7'b0110011:
            begin
                case (f3)
                    3'b000:  regs[rd] = instr[30] ? a - b : a + b;
                    3'b010:  regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b100:  regs[rd] = a ^ b;
                    3'b110:  regs[rd] = a | b;
                    default: regs[rd] = a & b;
                endcase
            end
            7'b0010011:
                regs[rd] = a + imm_i;
            7'b0000011:
            begin
                addr     = a + imm_i;
                regs[rd] = ref_mem[addr[11:2]];
            end
            7'b0100011:
            begin
                addr = a + imm_s;
                ref_mem[addr[11:2]] = b;
                exp_addr.push_back(addr);
                exp_data.push_back(b);
                // program ends with its halt store
                if (addr == HALT_ADDR)
                    return;
            end
            // beq on equal, bne on not equal
            7'b1100011:
                if ((a == b) != f3[0])
                    next_pc = pc + imm_b;
            7'b1101111:
            begin
                regs[rd] = pc + 32'd4;
                next_pc  = pc + imm_j;
            end
            default:
            begin
            end
        endcase
        regs[0] = '0;
        pc      = next_pc;
    end
endfunction

// ==== tb_rv_pipeline.sv ====
`timescale 1ns/10ps

module tb_rv_pipeline;

    localparam logic [31:0] RESET_PC  = 32'h0000_0000;
    localparam logic [31:0] HALT_ADDR = 32'h0000_07fc;
    localparam logic [31:0] SEED      = 32'h48d4_8700;
    localparam int MEM_WORDS      = 1024;
    localparam int REF_STEP_LIMIT = 200;
    // ~50 executed instructions, two transfers each, up to 4 cycles per transfer, 5x margin
    localparam int TIMEOUT_CYCLES = 50 * 2 * 4 * 5;

    logic        CLK       = 1'b0;
    logic        RESET     = 1'b1;
    logic        mem_ready = 1'b0;
    logic        mem_valid, mem_write;
    logic [31:0] mem_addr, mem_wdata, mem_rdata;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] ref_mem [MEM_WORDS];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          wait_left   = 0;
    int          cycle_count = 0;
    int          store_count = 0;
    logic        first_seen  = 1'b0;
    logic        waiting     = 1'b0;
    logic        held_write;
    logic [31:0] held_addr, held_wdata;

    `include "tb_rv_ref.svh"

    rv_pipeline_top #(.RESET_PC(RESET_PC)) u_rv_pipeline_top (
        .CLK       (CLK),
        .RESET     (RESET),
        .mem_valid (mem_valid),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

    function automatic logic [31:0] reg_op(int f7, int f3, int rd, int rs1, int rs2);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(int rd, int rs1, int imm);
        return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
    endfunction

    function automatic logic [31:0] load_word(int rd, int base, int off);
        return {12'(off), 5'(base), 3'b010, 5'(rd), 7'b0000011};
    endfunction

    function automatic logic [31:0] store_word(int src, int base, int off);
        logic [11:0] i;
        i = 12'(off);
        return {i[11:5], 5'(src), 5'(base), 3'b010, i[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch(int f3, int rs1, int rs2, int off);
        logic [12:0] i;
        i = 13'(off);
        return {i[12], i[10:5], 5'(rs2), 5'(rs1), 3'(f3), i[4:1], i[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jump_link(int rd, int off);
        logic [20:0] i;
        i = 21'(off);
        return {i[20], i[10:1], i[11], i[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic load_program();
        logic [31:0] prog [$];
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = 32'h5a5a_0000 ^ 32'(i);
        // dependent ALU chain, results stored from base x10
        prog.push_back(addi(1, 0, 5));
        prog.push_back(addi(2, 0, -3));
        prog.push_back(addi(10, 0, 1024));
        prog.push_back(reg_op(0, 0, 3, 1, 2));
        prog.push_back(reg_op(32, 0, 4, 3, 1));
        prog.push_back(store_word(3, 10, 0));
        prog.push_back(reg_op(0, 7, 5, 4, 2));
        prog.push_back(reg_op(0, 6, 6, 5, 1));
        prog.push_back(reg_op(0, 4, 7, 6, 4));
        prog.push_back(reg_op(0, 2, 8, 7, 1));
        prog.push_back(store_word(4, 10, 4));
        prog.push_back(store_word(5, 10, 8));
        prog.push_back(store_word(6, 10, 12));
        prog.push_back(store_word(7, 10, 16));
        prog.push_back(store_word(8, 10, 20));
        prog.push_back(addi(9, 8, 100));
        prog.push_back(store_word(9, 10, 24));
        // store then reload, one independent instruction before the use
        prog.push_back(store_word(7, 10, 28));
        prog.push_back(load_word(12, 10, 28));
        prog.push_back(addi(13, 0, 7));
        prog.push_back(reg_op(0, 0, 14, 12, 13));
        prog.push_back(store_word(14, 10, 32));
        prog.push_back(store_word(12, 10, 36));
        // beq not taken, bne taken, beq taken, bne not taken
        prog.push_back(branch(0, 1, 2, 8));
        prog.push_back(store_word(1, 10, 40));
        prog.push_back(branch(1, 1, 2, 8));
        prog.push_back(store_word(2, 10, 44));
        prog.push_back(branch(0, 1, 1, 8));
        prog.push_back(store_word(3, 10, 48));
        prog.push_back(branch(1, 3, 3, 8));
        prog.push_back(store_word(4, 10, 52));
        // jal over two stores, then store the link
        prog.push_back(jump_link(15, 12));
        prog.push_back(store_word(1, 10, 56));
        prog.push_back(store_word(2, 10, 60));
        prog.push_back(store_word(15, 10, 64));
        prog.push_back(addi(11, 0, 2044));
        prog.push_back(store_word(1, 11, 0));
        for (int i = 0; i < 4; i++)
            prog.push_back(addi(0, 0, 0));
        foreach (prog[i])
            mem[RESET_PC[11:2] + i] = prog[i];
    endtask

    task automatic stop_with_failure();
        $display("tests failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic compare_store();
        logic [31:0] want_addr, want_data;
        if (exp_addr.size() == 0)
        begin
            $display("store to %h after the expected store sequence had ended", mem_addr);
            stop_with_failure();
        end
        else
        begin
            want_addr = exp_addr.pop_front();
            want_data = exp_data.pop_front();
            check_value($sformatf("store %0d address", store_count), want_addr, mem_addr);
            check_value($sformatf("store %0d data", store_count), want_data, mem_wdata);
            store_count++;
            if (mem_addr == HALT_ADDR)
            begin
                if (exp_addr.size() == 0)
                begin
                    $display("all tests passed");
                    $finish;
                end
                else
                begin
                    $display("halt store came with %0d stores missing", exp_addr.size());
                    stop_with_failure();
                end
            end
        end
    endtask

    initial
    begin
        forever
            #20 CLK = ~CLK;
    end

    initial
    begin
        load_program();
        ref_mem = mem;
        ref_run();
        repeat (2) @(posedge CLK);
        RESET <= 1'b0;
    end

    // memory model, zero to three wait cycles per transfer
    initial
    begin
        void'($urandom(SEED));
        forever
        begin
            @(posedge CLK);
            if (mem_valid && mem_ready)
            begin
                if (mem_write)
                    mem[mem_addr[11:2]] <= mem_wdata;
                wait_left = $urandom_range(3, 0);
            end
            else if (mem_valid && wait_left > 0)
                wait_left = wait_left - 1;
            mem_ready <= mem_valid && (wait_left == 0);
        end
    end

    assign mem_rdata = mem[mem_addr[11:2]];

    // port checks on the falling edge, where everything has settled
    always @(negedge CLK)
    begin
        if (RESET)
            check_value("mem_valid during reset", 32'd0, 32'(mem_valid));
        else
        begin
            if (!first_seen)
            begin
                check_value("first request valid", 32'd1, 32'(mem_valid));
                check_value("first request address", RESET_PC, mem_addr);
                check_value("first request write flag", 32'd0, 32'(mem_write));
                first_seen = 1'b1;
            end
            // a waiting request holds still
            if (waiting)
            begin
                check_value("held address", held_addr, mem_addr);
                check_value("held write flag", 32'(held_write), 32'(mem_write));
                check_value("held write data", held_wdata, mem_wdata);
            end
            waiting    = mem_valid && !mem_ready;
            held_addr  = mem_addr;
            held_write = mem_write;
            held_wdata = mem_wdata;
            if (mem_valid && mem_ready && mem_write)
                compare_store();
        end
    end

    always @(posedge CLK)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, the CPU never reached the halt store",
                     cycle_count);
            stop_with_failure();
        end
    end

endmodule

// ==== verilog.f ====
+incdir+.
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
execute_stage.sv
mem_wb_stage.sv
mem_arbiter.sv
rv_pipeline_top.sv
tb_rv_pipeline.sv
